// File: common/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// datapath widths
`define LSU_XLEN        32
`define LSU_STRB_W      (`LSU_XLEN / 8)
`define LSU_OFF_W       2             // byte offset inside a word

// data memory geometry
`define LSU_MEM_WORDS   256
`define LSU_MEM_AW      8

// destination register number
`define LSU_RF_AW       5

// operation encodings
`define LSU_OP_W        3
`define LSU_OP_LD_B     3'd0
`define LSU_OP_LD_BU    3'd1
`define LSU_OP_LD_H     3'd2
`define LSU_OP_LD_HU    3'd3
`define LSU_OP_LD_W     3'd4
`define LSU_OP_ST_B     3'd5
`define LSU_OP_ST_H     3'd6
`define LSU_OP_ST_W     3'd7

`endif

// File: common/lsu_pkg.sv
`default_nettype none

`include "lsu_consts.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0]   word_t;
    typedef logic [`LSU_MEM_AW-1:0] mem_addr_t;
    typedef logic [`LSU_RF_AW-1:0]  rf_addr_t;
    typedef logic [`LSU_STRB_W-1:0] strb_t;
    typedef logic [`LSU_OFF_W-1:0]  byte_off_t;

    typedef enum logic [`LSU_OP_W-1:0] {
        LSU_LD_B  = `LSU_OP_LD_B,
        LSU_LD_BU = `LSU_OP_LD_BU,
        LSU_LD_H  = `LSU_OP_LD_H,
        LSU_LD_HU = `LSU_OP_LD_HU,
        LSU_LD_W  = `LSU_OP_LD_W,
        LSU_ST_B  = `LSU_OP_ST_B,
        LSU_ST_H  = `LSU_OP_ST_H,
        LSU_ST_W  = `LSU_OP_ST_W
    } lsu_op_e;

    // instruction as it enters the execute stage
    typedef struct packed {
        lsu_op_e  op;
        word_t    base;
        word_t    offset;
        word_t    wdata;      // store data, low bits used for st_b/st_h
        rf_addr_t rd;
    } lsu_req_t;

    // execute to memory stage record
    typedef struct packed {
        lsu_op_e   op;
        byte_off_t addr_lo;
        rf_addr_t  rd;
        logic      res_from_mem;
        logic      rf_we;
        logic      ex;        // misaligned access
    } es2ms_t;

    // write-back record
    typedef struct packed {
        logic     rf_we;
        rf_addr_t rd;
        word_t    wdata;
        logic     ex;
    } ms2ws_t;

    // one word request to the data SRAM
    typedef struct packed {
        logic      we;
        strb_t     strb;
        mem_addr_t addr;
        word_t     wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// File: src/data_sram.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module data_sram (
    input  wire               clk,
    input  wire               en,
    input  lsu_pkg::mem_req_t req,
    output lsu_pkg::word_t    rdata
);

    lsu_pkg::word_t mem [0:`LSU_MEM_WORDS-1];

    always_ff @(posedge clk) begin
        if (en) begin
            if (req.we) begin
                for (int i = 0; i < `LSU_STRB_W; i++) begin
                    if (req.strb[i])
                        mem[req.addr][i*8 +: 8] <= req.wdata[i*8 +: 8];
                end
            end
            rdata <= mem[req.addr];   // old contents on a write
        end
    end

endmodule

`default_nettype wire

// File: src/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  wire               clk,
    input  wire               resetn,
    input  wire               exe_mem_valid,
    input  lsu_pkg::mem_req_t exe_mem_req,
    input  wire               host_mem_valid,
    input  lsu_pkg::mem_req_t host_mem_req,
    output logic              exe_grant,
    output logic              host_grant,
    output logic              sram_en,
    output lsu_pkg::mem_req_t sram_req
);

    logic last_host;  // host won the previous arbitration

    // on a tie the side that lost last time goes first
    assign exe_grant  = exe_mem_valid & (~host_mem_valid | last_host);
    assign host_grant = host_mem_valid & ~exe_grant;

    assign sram_en  = exe_grant | host_grant;
    assign sram_req = host_grant ? host_mem_req : exe_mem_req;

    always_ff @(posedge clk) begin
        if (~resetn)
            last_host <= 1'b0;
        else if (sram_en)
            last_host <= host_grant;
    end

endmodule

`default_nettype wire

// File: src/apb_mem_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module apb_mem_port (
    input  wire               clk,
    input  wire               resetn,
    input  wire               psel,
    input  wire               penable,
    input  wire               pwrite,
    input  lsu_pkg::word_t    paddr,
    input  lsu_pkg::word_t    pwdata,
    input  wire               host_grant,
    input  lsu_pkg::word_t    rdata,
    output logic              pready,
    output lsu_pkg::word_t    prdata,
    output logic              host_mem_valid,
    output lsu_pkg::mem_req_t host_mem_req
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_DONE
    } apb_state_e;

    apb_state_e state;

    always_ff @(posedge clk) begin
        if (~resetn) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (psel & ~penable) state <= ST_REQ;   // setup phase seen
                ST_REQ:  if (host_grant) state <= ST_DONE;
                ST_DONE: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ask for the port only during the access phase
    assign host_mem_valid = (state == ST_REQ) & psel & penable;

    // host writes are always full word
    assign host_mem_req.we    = pwrite;
    assign host_mem_req.strb  = {`LSU_STRB_W{1'b1}};
    assign host_mem_req.addr  = paddr[`LSU_MEM_AW+1:2];
    assign host_mem_req.wdata = pwdata;

    // sram data lands in the cycle after the grant
    assign pready = (state == ST_DONE);
    assign prdata = pready ? rdata : '0;

endmodule

`default_nettype wire

// File: exe_stage/exe_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module exe_stage (
    input  wire               clk,
    input  wire               resetn,
    input  wire               in_valid,
    input  lsu_pkg::lsu_req_t in_req,
    input  wire               ms_allowin,
    input  wire               exe_grant,
    output logic              in_allowin,
    output logic              es2ms_valid,
    output lsu_pkg::es2ms_t   es2ms,
    output logic              exe_mem_valid,
    output lsu_pkg::mem_req_t exe_mem_req
);

    logic              es_valid;
    lsu_pkg::lsu_req_t es_req;
    lsu_pkg::word_t    es_addr;
    logic              is_store;
    logic              is_half;
    logic              is_word;
    logic              es_ex;
    logic              es_ready_go;
    lsu_pkg::strb_t    st_strb;
    lsu_pkg::word_t    st_data;

    // handshake, a misaligned op never touches memory
    assign es_ready_go = es_ex | exe_grant;
    assign in_allowin  = ~es_valid | (es_ready_go & ms_allowin);
    assign es2ms_valid = es_valid & es_ready_go;

    always_ff @(posedge clk) begin
        if (~resetn)
            es_valid <= 1'b0;
        else if (in_allowin)
            es_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (in_valid & in_allowin)
            es_req <= in_req;
    end

    assign es_addr  = es_req.base + es_req.offset;
    assign is_store = (es_req.op == lsu_pkg::LSU_ST_B) | (es_req.op == lsu_pkg::LSU_ST_H) |
                      (es_req.op == lsu_pkg::LSU_ST_W);
    assign is_half  = (es_req.op == lsu_pkg::LSU_LD_H) | (es_req.op == lsu_pkg::LSU_LD_HU) |
                      (es_req.op == lsu_pkg::LSU_ST_H);
    assign is_word  = (es_req.op == lsu_pkg::LSU_LD_W) | (es_req.op == lsu_pkg::LSU_ST_W);
    assign es_ex    = is_half & es_addr[0] | is_word & (|es_addr[1:0]);

    // move store data into its byte lane
    always_comb begin
        case (es_req.op)
            lsu_pkg::LSU_ST_B: begin
                st_strb = lsu_pkg::strb_t'(1) << es_addr[1:0];
                st_data = {(`LSU_XLEN/8){es_req.wdata[7:0]}};
            end
            lsu_pkg::LSU_ST_H: begin
                st_strb = lsu_pkg::strb_t'(3) << es_addr[1:0];
                st_data = {(`LSU_XLEN/16){es_req.wdata[15:0]}};
            end
            lsu_pkg::LSU_ST_W: begin
                st_strb = {`LSU_STRB_W{1'b1}};
                st_data = es_req.wdata;
            end
            default: begin     // loads write nothing
                st_strb = '0;
                st_data = es_req.wdata;
            end
        endcase
    end

    // only ask when the memory stage can take the result this cycle
    assign exe_mem_valid     = es_valid & ~es_ex & ms_allowin;
    assign exe_mem_req.we    = is_store;
    assign exe_mem_req.strb  = st_strb;
    assign exe_mem_req.addr  = es_addr[`LSU_MEM_AW+1:2];
    assign exe_mem_req.wdata = st_data;

    assign es2ms.op           = es_req.op;
    assign es2ms.addr_lo      = es_addr[`LSU_OFF_W-1:0];
    assign es2ms.rd           = es_req.rd;
    assign es2ms.res_from_mem = ~is_store & ~es_ex;
    assign es2ms.rf_we        = ~is_store & ~es_ex;
    assign es2ms.ex           = es_ex;

endmodule

`default_nettype wire

// File: mem_stage/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module mem_stage (
    input  wire             clk,
    input  wire             resetn,
    input  wire             es2ms_valid,
    input  lsu_pkg::es2ms_t es2ms,
    input  lsu_pkg::word_t  rdata,
    input  wire             wb_allowin,
    output logic            ms_allowin,
    output logic            wb_valid,
    output lsu_pkg::ms2ws_t wb
);

    logic            ms_valid;
    logic            ms_fresh;    // first cycle after accept, rdata is live
    lsu_pkg::es2ms_t ms_rec;
    lsu_pkg::word_t  rdata_q;
    lsu_pkg::word_t  ld_word;
    lsu_pkg::word_t  shift_rdata;
    lsu_pkg::word_t  mem_result;

    assign ms_allowin = ~ms_valid | wb_allowin;
    assign wb_valid   = ms_valid;

    always_ff @(posedge clk) begin
        if (~resetn) begin
            ms_valid <= 1'b0;
            ms_fresh <= 1'b0;
        end else begin
            if (ms_allowin)
                ms_valid <= es2ms_valid;
            ms_fresh <= es2ms_valid & ms_allowin;
        end
    end

    always_ff @(posedge clk) begin
        if (es2ms_valid & ms_allowin)
            ms_rec <= es2ms;
    end

    // keep the sram word so a stall does not lose it
    always_ff @(posedge clk) begin
        if (ms_fresh)
            rdata_q <= rdata;
    end

    assign ld_word     = ms_fresh ? rdata : rdata_q;
    assign shift_rdata = ld_word >> {ms_rec.addr_lo, 3'b000};

    // sign or zero extend the selected lane
    always_comb begin
        case (ms_rec.op)
            lsu_pkg::LSU_LD_B:  mem_result = {{(`LSU_XLEN-8){shift_rdata[7]}}, shift_rdata[7:0]};
            lsu_pkg::LSU_LD_BU: mem_result = {{(`LSU_XLEN-8){1'b0}}, shift_rdata[7:0]};
            lsu_pkg::LSU_LD_H:  mem_result = {{(`LSU_XLEN-16){shift_rdata[15]}},
                                              shift_rdata[15:0]};
            lsu_pkg::LSU_LD_HU: mem_result = {{(`LSU_XLEN-16){1'b0}}, shift_rdata[15:0]};
            default:            mem_result = shift_rdata;    // ld_w
        endcase
    end

    assign wb.rf_we = ms_valid & ms_rec.rf_we;
    assign wb.rd    = ms_rec.rd;
    assign wb.wdata = ms_rec.res_from_mem ? mem_result : '0;   // stores and faults give zero
    assign wb.ex    = ms_rec.ex;

endmodule

`default_nettype wire

// File: src/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  wire               clk,
    input  wire               resetn,
    // instruction input
    input  wire               in_valid,
    output logic              in_allowin,
    input  lsu_pkg::lsu_req_t in_req,
    // write-back output
    output logic              wb_valid,
    input  wire               wb_allowin,
    output lsu_pkg::ms2ws_t   wb,
    // host APB port
    input  wire               psel,
    input  wire               penable,
    input  wire               pwrite,
    input  lsu_pkg::word_t    paddr,
    input  lsu_pkg::word_t    pwdata,
    output logic              pready,
    output lsu_pkg::word_t    prdata
);

    logic              ms_allowin;
    logic              es2ms_valid;
    lsu_pkg::es2ms_t   es2ms;
    logic              exe_mem_valid;
    lsu_pkg::mem_req_t exe_mem_req;
    logic              exe_grant;
    logic              host_mem_valid;
    lsu_pkg::mem_req_t host_mem_req;
    logic              host_grant;
    logic              sram_en;
    lsu_pkg::mem_req_t sram_req;
    lsu_pkg::word_t    rdata;    // shared by the memory stage and host port

    exe_stage u_exe_stage (
        .clk           (clk),
        .resetn        (resetn),
        .in_valid      (in_valid),
        .in_req        (in_req),
        .ms_allowin    (ms_allowin),
        .exe_grant     (exe_grant),
        .in_allowin    (in_allowin),
        .es2ms_valid   (es2ms_valid),
        .es2ms         (es2ms),
        .exe_mem_valid (exe_mem_valid),
        .exe_mem_req   (exe_mem_req)
    );

    mem_stage u_mem_stage (
        .clk         (clk),
        .resetn      (resetn),
        .es2ms_valid (es2ms_valid),
        .es2ms       (es2ms),
        .rdata       (rdata),
        .wb_allowin  (wb_allowin),
        .ms_allowin  (ms_allowin),
        .wb_valid    (wb_valid),
        .wb          (wb)
    );

    mem_arbiter u_mem_arbiter (
        .clk            (clk),
        .resetn         (resetn),
        .exe_mem_valid  (exe_mem_valid),
        .exe_mem_req    (exe_mem_req),
        .host_mem_valid (host_mem_valid),
        .host_mem_req   (host_mem_req),
        .exe_grant      (exe_grant),
        .host_grant     (host_grant),
        .sram_en        (sram_en),
        .sram_req       (sram_req)
    );

    data_sram u_data_sram (
        .clk   (clk),
        .en    (sram_en),
        .req   (sram_req),
        .rdata (rdata)
    );

    apb_mem_port u_apb_mem_port (
        .clk            (clk),
        .resetn         (resetn),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .host_grant     (host_grant),
        .rdata          (rdata),
        .pready         (pready),
        .prdata         (prdata),
        .host_mem_valid (host_mem_valid),
        .host_mem_req   (host_mem_req)
    );

endmodule

`default_nettype wire

// File: verif/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_tb;

    localparam int TMO = 200;    // cycles allowed per wait loop

    logic              clk = 1'b0;
    logic              resetn;
    logic              in_valid;
    logic              in_allowin;
    lsu_pkg::lsu_req_t in_req;
    logic              wb_valid;
    logic              wb_allowin;
    lsu_pkg::ms2ws_t   wb;
    logic              psel;
    logic              penable;
    logic              pwrite;
    lsu_pkg::word_t    paddr;
    lsu_pkg::word_t    pwdata;
    logic              pready;
    lsu_pkg::word_t    prdata;

    integer            seed = 45120;
    int                cyc = 0;
    int                checks = 0;
    int                errors = 0;
    int                t_checks;
    int                t_errors;
    int                wb_cnt = 0;
    int                wb_cyc = 0;
    int                accept_cyc = 0;
    logic              stall_en = 1'b0;
    string             cur_test = "reset";
    lsu_pkg::word_t    model [0:`LSU_MEM_WORDS-1];    // reference data memory
    lsu_pkg::ms2ws_t   exp_q [$];                     // expected records, in order

    lsu_top dut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    task automatic compare_val(input string name, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, exp_v, act_v);
        end
    endtask

    task automatic abort(input string what);
        errors++;
        $display("timeout in test %s: %s", cur_test, what);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        t_checks = checks;
        t_errors = errors;
    endtask

    task automatic report_test();
        $display("test %s: %0d checks, %0d errors", cur_test, checks - t_checks,
                 errors - t_errors);
    endtask

    // random instruction aimed at words 0..127, the host keeps to 128..255 meanwhile
    function automatic lsu_pkg::lsu_req_t gen_req(input int kind);
        lsu_pkg::lsu_req_t r;
        logic [31:0]       t;
        logic [31:0]       u;
        logic [1:0]        lo;
        logic              mis;
        int                v;
        t = rnd();
        u = rnd();
        v = int'(t[7:0] % 5);
        mis = (kind == 2) || (kind == 3 && t[10:8] == 3'd0);
        if (kind == 0)
            r.op = lsu_pkg::lsu_op_e'(3'(v));                      // loads only
        else if (kind == 2)
            r.op = lsu_pkg::lsu_op_e'(3'(v < 3 ? v + 2 : v + 3));  // half or word ops
        else
            r.op = lsu_pkg::lsu_op_e'(t[2:0]);
        lo = t[12:11];
        if (r.op inside {lsu_pkg::LSU_LD_H, lsu_pkg::LSU_LD_HU, lsu_pkg::LSU_ST_H})
            lo[0] = mis;
        else if (r.op inside {lsu_pkg::LSU_LD_W, lsu_pkg::LSU_ST_W})
            lo = !mis ? 2'b00 : (lo == 2'b00 ? 2'b11 : lo);
        r.offset = rnd();
        r.base = {u[31:10], 1'b0, t[19:13], lo} - r.offset;
        r.wdata = rnd();
        r.rd = t[27:23];
        return r;
    endfunction

    // expected record of one accepted instruction, stores also update the model
    function automatic lsu_pkg::ms2ws_t model_step(input lsu_pkg::lsu_req_t r);
        lsu_pkg::ms2ws_t    e;
        lsu_pkg::word_t     a;
        lsu_pkg::word_t     w;
        lsu_pkg::mem_addr_t idx;
        logic [4:0]         sh;
        a = r.base + r.offset;
        idx = a[`LSU_MEM_AW+1:2];
        sh = {a[1:0], 3'b000};
        w = model[idx] >> sh;    // addressed lane at the bottom
        e = '0;
        e.rd = r.rd;
        case (r.op)
            lsu_pkg::LSU_LD_H, lsu_pkg::LSU_LD_HU, lsu_pkg::LSU_ST_H: e.ex = a[0];
            lsu_pkg::LSU_LD_W, lsu_pkg::LSU_ST_W:                    e.ex = |a[1:0];
            default:                                                 e.ex = 1'b0;
        endcase
        if (!e.ex) begin
            case (r.op)
                lsu_pkg::LSU_LD_B:  e.wdata = {{24{w[7]}}, w[7:0]};
                lsu_pkg::LSU_LD_BU: e.wdata = {24'b0, w[7:0]};
                lsu_pkg::LSU_LD_H:  e.wdata = {{16{w[15]}}, w[15:0]};
                lsu_pkg::LSU_LD_HU: e.wdata = {16'b0, w[15:0]};
                lsu_pkg::LSU_LD_W:  e.wdata = w;
                lsu_pkg::LSU_ST_B:  model[idx][sh +: 8] = r.wdata[7:0];
                lsu_pkg::LSU_ST_H:  model[idx][sh +: 16] = r.wdata[15:0];
                default:            model[idx] = r.wdata;
            endcase
        end
        e.rf_we = !e.ex &&
                  !(r.op inside {lsu_pkg::LSU_ST_B, lsu_pkg::LSU_ST_H, lsu_pkg::LSU_ST_W});
        return e;
    endfunction

    task automatic issue(input lsu_pkg::lsu_req_t r);
        int t;
        in_valid = 1'b1;
        in_req = r;
        t = 0;
        @(negedge clk);
        while (!in_allowin && t < TMO) begin
            t++;
            @(negedge clk);
        end
        if (!in_allowin)
            abort("instruction was never accepted");
        exp_q.push_back(model_step(r));
        accept_cyc = cyc;
        step();
        in_valid = 1'b0;
    endtask

    task automatic run_ops(input int n, input int kind);
        logic [31:0] g;
        for (int k = 0; k < n; k++) begin
            issue(gen_req(kind));
            g = rnd();
            if (g[1:0] == 2'b00)
                repeat (int'(g[3:2])) step();    // occasional bubble
        end
    endtask

    task automatic drain();
        int t;
        t = 0;
        while (exp_q.size() != 0 && t < TMO) begin
            t++;
            @(negedge clk);
        end
        if (exp_q.size() != 0)
            abort("write-back records are missing");
        step();
    endtask

    // one APB transfer, a read is checked against the model
    task automatic apb_xfer(input logic wr, input lsu_pkg::mem_addr_t idx,
                            input lsu_pkg::word_t d);
        int t;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = lsu_pkg::word_t'(idx) << 2;
        pwdata = d;
        step();
        penable = 1'b1;
        t = 0;
        @(negedge clk);
        while (!pready && t < TMO) begin
            t++;
            @(negedge clk);
        end
        if (!pready)
            abort("APB transfer never completed");
        if (wr)
            model[idx] = d;
        else
            compare_val(cur_test, 64'(model[idx]), 64'(prdata));
        step();
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic sweep_check(input int lo, input int hi);
        for (int j = lo; j <= hi; j++)
            apb_xfer(1'b0, lsu_pkg::mem_addr_t'(j), '0);
    endtask

    task automatic watch_wb();
        lsu_pkg::ms2ws_t e;
        forever begin
            @(negedge clk);
            if (resetn && wb_valid && wb_allowin) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("unexpected write-back record %h in test %s", wb, cur_test);
                end else begin
                    e = exp_q.pop_front();
                    compare_val(cur_test, 64'(e), 64'(wb));
                end
                wb_cnt++;
                wb_cyc = cyc;
            end
        end
    endtask

    task automatic drive_backpressure();
        logic [31:0] s;
        forever begin
            step();
            s = rnd();
            wb_allowin = stall_en ? (s[1:0] != 2'b00) : 1'b1;    // low about 1 in 4
        end
    endtask

    initial begin
        int                 i;
        int                 t;
        int                 n0;
        lsu_pkg::mem_addr_t a;
        resetn = 1'b0;
        in_valid = 1'b0;
        in_req = '0;
        wb_allowin = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        fork
            watch_wb();
            drive_backpressure();
        join_none
        repeat (10) @(posedge clk);
        #2;
        resetn = 1'b1;

        begin_test("apb_rw");    // preload every word, then read all back
        for (i = 0; i < `LSU_MEM_WORDS; i++)
            apb_xfer(1'b1, lsu_pkg::mem_addr_t'(i), rnd());
        sweep_check(0, `LSU_MEM_WORDS - 1);
        report_test();

        begin_test("loads");
        run_ops(40, 0);
        drain();
        report_test();

        begin_test("stores");
        run_ops(40, 1);
        drain();
        sweep_check(0, 127);
        report_test();

        begin_test("misalign");
        run_ops(20, 2);
        drain();
        sweep_check(0, 127);
        report_test();

        begin_test("stall");
        stall_en = 1'b1;
        run_ops(60, 1);
        drain();
        stall_en = 1'b0;
        report_test();

        begin_test("contention");
        stall_en = 1'b1;
        fork
            run_ops(60, 3);
            for (i = 0; i < 30; i++) begin
                a = {1'b1, 7'(rnd())};
                apb_xfer(1'b1, a, rnd());
                apb_xfer(1'b0, a, '0);
            end
        join
        drain();
        stall_en = 1'b0;
        report_test();

        begin_test("latency");
        repeat (2) step();
        for (i = 0; i < 8; i++) begin
            n0 = wb_cnt;
            issue(gen_req(1));
            t = 0;
            while (wb_cnt == n0 && t < TMO) begin
                t++;
                @(negedge clk);
            end
            if (wb_cnt == n0)
                abort("no write-back record appeared");
            compare_val(cur_test, 64'(2), 64'(wb_cyc - accept_cyc));
            repeat (3) step();
        end
        report_test();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: lsu_top.f
+incdir+common
common/lsu_pkg.sv
src/data_sram.sv
src/mem_arbiter.sv
src/apb_mem_port.sv
exe_stage/exe_stage.sv
mem_stage/mem_stage.sv
src/lsu_top.sv
verif/lsu_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --timing --timescale 1ns/1ps
TOP       = lsu_tb
RTL_TOP   = lsu_top
FILELIST  = lsu_top.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = TESTS FAILED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported a failure"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
